// ==== build.f ====
design/vdp_pkg.sv
design/vdp_regs.sv
design/vram.sv
design/dl_decoder.sv
design/text_fetch.sv
design/line_writer.sv
design/vdp_top.sv
verification/tb_clock.sv
verification/vdp_asserts.sv
verification/vdp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vdp_tb
FLIST     ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/vdp_tb.sv ====
`timescale 1ns/1ps

module vdp_tb
   import vdp_pkg::*;
();

   localparam int COLS      = 8;
   localparam int VRAM_AW   = 12;
   localparam int CREDITS   = 2;
   localparam int XW        = $clog2(COLS * 8);
   localparam int MASK      = 2**(VRAM_AW + 1) - 1; // byte address wrap
   localparam int LINE_CYC  = 40 + 12 * COLS;
   localparam int N_LINES   = 26;
   localparam int SETUP_CYC = 2 * 400;                // about 400 register writes
   localparam int LIMIT     = N_LINES * LINE_CYC + SETUP_CYC + 500;

   // vram layout, byte addresses except the list
   localparam int DL_WORD = 'h100;
   localparam int TEXT_A  = 'h041;                    // odd start, high byte lane
   localparam int ATTR_A  = 'h060;
   localparam int TEXT_B  = 'h080;
   localparam int ATTR_B  = 'h0c3;
   localparam int CS_BASE = 2;
   localparam int N_CODES = 32;

   logic          sys_clk;
   logic          rst_n;
   logic [15:0]   cpu_addr;
   byte_t         cpu_wr_data;
   logic          cpu_wr_en;
   logic          frame_start;
   logic          line_start;
   byte_t         cpu_rd_data;
   logic          pix_valid;
   logic [XW-1:0] pix_x;
   color_t        pix_color;

   byte_t  img [MASK + 1];
   color_t exp_color [COLS * 8];
   word_t  dl_words [8];
   int     exp_cnt;
   int     line_base;
   int     got_total;
   int     pix_errs;
   int     chk_errs;
   int     mark_errs;
   int     n_tests;
   int     n_failed;
   int     cycles;
   int     seed;
   int     vaddr_m;

   tb_clock u_clock (
      .sys_clk(sys_clk),
      .rst_n  (rst_n)
   );

   vdp_top #(
      .COLS   (COLS),
      .VRAM_AW(VRAM_AW),
      .CREDITS(CREDITS)
   ) uut (
      .sys_clk    (sys_clk),
      .rst_n      (rst_n),
      .cpu_addr   (cpu_addr),
      .cpu_wr_data(cpu_wr_data),
      .cpu_wr_en  (cpu_wr_en),
      .frame_start(frame_start),
      .line_start (line_start),
      .cpu_rd_data(cpu_rd_data),
      .pix_valid  (pix_valid),
      .pix_x      (pix_x),
      .pix_color  (pix_color)
   );

   function automatic color_t ref_pixel(input int t_base, input int a_base,
                                        input int line_idx, input int x);
      int    row;
      int    col;
      byte_t code;
      byte_t attr;
      byte_t font;
      row  = line_idx / ROW_LINES;
      col  = x / 8;
      code = img[(t_base + row * COLS + col) & MASK];
      attr = img[(a_base + row * COLS + col) & MASK];
      font = img[(CS_BASE * 1024 + int'(code) * 8 + line_idx % ROW_LINES) & MASK];
      if (font[7 - x % 8])
         return attr[3:0];
      return attr[7:4];
   endfunction

   task automatic write_reg(input logic [6:0] off, input byte_t d);
      @(posedge sys_clk);
      cpu_addr    <= {REG_BASE, off};
      cpu_wr_data <= d;
      cpu_wr_en   <= 1'b1;
      @(posedge sys_clk);
      cpu_wr_en   <= 1'b0;
   endtask

   task automatic check_reg(input logic [6:0] off, input byte_t exp, input string name);
      @(posedge sys_clk);
      cpu_addr <= {REG_BASE, off};
      @(posedge sys_clk);
      @(negedge sys_clk);
      if (cpu_rd_data != exp) begin
         $display("FAIL %0t cpu_rd_data[%s] expected %h got %h", $time, name, exp,
                  cpu_rd_data);
         chk_errs++;
      end
   endtask

   task automatic set_vaddr(input int a);
      write_reg(REG_VADDR_LO, byte_t'(a));
      write_reg(REG_VADDR_HI, byte_t'(a >> 8));
      vaddr_m = a;
   endtask

   task automatic write_data(input byte_t d);
      write_reg(REG_VDATA, d);
      img[vaddr_m & MASK] = d;
      vaddr_m = (vaddr_m + 1) & 'hffff;
   endtask

   task automatic check_vaddr(input int exp);
      check_reg(REG_VADDR_LO, byte_t'(exp), "vaddr_lo");
      check_reg(REG_VADDR_HI, byte_t'(exp >> 8), "vaddr_hi");
   endtask

   task automatic load_random(input int addr, input int n, input byte_t keep);
      set_vaddr(addr);
      for (int i = 0; i < n; i++)
         write_data(byte_t'($random(seed)) & keep);
      check_vaddr(addr + n);
   endtask

   task automatic pulse_frame();
      @(posedge sys_clk);
      frame_start <= 1'b1;
      @(posedge sys_clk);
      frame_start <= 1'b0;
   endtask

   task automatic run_line(input bit is_text, input int t_base, input int a_base,
                           input int line_idx);
      int got;
      exp_cnt = is_text ? COLS * 8 : 0;
      for (int x = 0; x < COLS * 8; x++)
         exp_color[x] = ref_pixel(t_base, a_base, line_idx, x);
      line_base = got_total;
      @(posedge sys_clk);
      line_start <= 1'b1;
      @(posedge sys_clk);
      line_start <= 1'b0;
      repeat (LINE_CYC - 1) @(posedge sys_clk);
      got = got_total - line_base;
      if (got != exp_cnt) begin
         $display("%0t: line %0d gave %0d pixels instead of %0d", $time, line_idx, got,
                  exp_cnt);
         chk_errs++;
      end
   endtask

   task automatic report_test(input string name);
      int errs;
      errs = pix_errs + chk_errs;
      n_tests++;
      if (errs == mark_errs) begin
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         $display("test %0d %s: %0d errors", n_tests, name, errs - mark_errs);
         n_failed++;
      end
      mark_errs = errs;
   endtask

   // pixel checker, outputs are settled by the falling edge
   always @(negedge sys_clk) begin
      int idx;
      if (pix_valid === 1'b1) begin
         idx = got_total - line_base;
         if (idx >= exp_cnt) begin
            $display("%0t: pixel at x %0d where none was expected", $time, pix_x);
            pix_errs++;
         end else begin
            if (int'(pix_x) != idx) begin
               $display("FAIL %0t pix_x expected %0d got %0d", $time, idx, pix_x);
               pix_errs++;
            end
            if (pix_color != exp_color[idx]) begin
               $display("FAIL %0t pix_color[%0d] expected %h got %h", $time, idx,
                        exp_color[idx], pix_color);
               pix_errs++;
            end
         end
         got_total++;
      end
   end

   always @(posedge sys_clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: run still going after %0d cycles", LIMIT);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      cpu_addr    = '0;
      cpu_wr_data = '0;
      cpu_wr_en   = 1'b0;
      frame_start = 1'b0;
      line_start  = 1'b0;
      cycles      = 0;
      got_total   = 0;
      line_base   = 0;
      exp_cnt     = 0;
      pix_errs    = 0;
      chk_errs    = 0;
      mark_errs   = 0;
      n_tests     = 0;
      n_failed    = 0;
      vaddr_m     = 0;
      seed        = 32'hf4d1;
      dl_words    = '{{4'h0, DL_TEXT, 8'd1}, word_t'(TEXT_A), word_t'(ATTR_A),
                      {4'h0, DL_TEXT, 8'd16}, word_t'(TEXT_B), word_t'(ATTR_B),
                      {4'h0, DL_BLANK, 8'd2}, {4'h0, DL_END, 8'd0}};
      wait (rst_n === 1'b1);

      write_reg(REG_DL_LO, byte_t'(DL_WORD));
      write_reg(REG_DL_HI, byte_t'(DL_WORD >> 8));
      write_reg(REG_CHARSET, byte_t'(CS_BASE));
      set_vaddr('h1234);
      check_reg(REG_DL_LO, byte_t'(DL_WORD), "dl_lo");
      check_reg(REG_DL_HI, byte_t'(DL_WORD >> 8), "dl_hi");
      check_reg(REG_CHARSET, byte_t'(CS_BASE), "charset");
      check_vaddr('h1234);
      for (int i = 0; i < 3; i++)
         write_data(byte_t'($random(seed)));
      check_vaddr('h1237);
      report_test("register readback");

      set_vaddr(DL_WORD * 2);
      foreach (dl_words[i]) begin
         write_data(dl_words[i][7:0]); // low byte at the even address
         write_data(dl_words[i][15:8]);
      end
      check_vaddr(DL_WORD * 2 + 16);
      load_random(TEXT_A, COLS, byte_t'(N_CODES - 1));
      load_random(ATTR_A, COLS, 8'hff);
      load_random(TEXT_B, 2 * COLS, byte_t'(N_CODES - 1));
      load_random(ATTR_B, 2 * COLS, 8'hff);
      load_random(CS_BASE * 1024, N_CODES * 8, 8'hff);
      report_test("vram auto-increment load");

      pulse_frame();
      run_line(1'b1, TEXT_A, ATTR_A, 0);
      report_test("single text scanline");

      for (int l = 0; l < 16; l++)
         run_line(1'b1, TEXT_B, ATTR_B, l);
      report_test("row advance");

      for (int l = 0; l < 4; l++)
         run_line(1'b0, 0, 0, 0); // two blank lines, then past the end marker
      report_test("blank and end entries");

      pulse_frame();
      run_line(1'b1, TEXT_A, ATTR_A, 0);
      run_line(1'b1, TEXT_B, ATTR_B, 0);
      run_line(1'b1, TEXT_B, ATTR_B, 1);
      pulse_frame();
      run_line(1'b1, TEXT_A, ATTR_A, 0);
      run_line(1'b1, TEXT_B, ATTR_B, 0);
      report_test("frame restart");

      $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests,
               n_tests - n_failed, n_failed, pix_errs + chk_errs);
      if (n_failed == 0 && pix_errs + chk_errs == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// ==== verification/vdp_asserts.sv ====
`timescale 1ns/1ps

module vdp_asserts #(
   parameter  int CREDITS = 2,
   localparam int CRW     = $clog2(CREDITS + 1)
) (
   input logic           sys_clk,
   input logic           rst_n,
   input logic           grp_valid,
   input logic           credit_ret,
   input logic [CRW-1:0] credits
);

   logic [CRW:0] in_flight; // groups handed to the writer and not yet returned

   always_ff @(posedge sys_clk) begin
      if (!rst_n)
         in_flight <= '0;
      else
         in_flight <= in_flight + (CRW + 1)'(grp_valid) - (CRW + 1)'(credit_ret);
   end

   // all writer slots taken means no credit is left
   a_send_with_credit: assert property (@(posedge sys_clk) disable iff (!rst_n)
      grp_valid |-> in_flight < (CRW + 1)'(CREDITS))
      else $error("group sent with no credit held");

   a_credit_max: assert property (@(posedge sys_clk) disable iff (!rst_n)
      credits <= CRW'(CREDITS))
      else $error("credit count above %0d", CREDITS);

   a_ret_outstanding: assert property (@(posedge sys_clk) disable iff (!rst_n)
      credit_ret |-> credits != CRW'(CREDITS))
      else $error("credit returned while all credits were held");

endmodule

bind text_fetch vdp_asserts #(
   .CREDITS(CREDITS)
) u_asserts (
   .sys_clk   (sys_clk),
   .rst_n     (rst_n),
   .grp_valid (grp_valid),
   .credit_ret(credit_ret),
   .credits   (credits)
);

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
   parameter real PERIOD     = 20.0,
   parameter int  RST_CYCLES = 3
) (
   output logic sys_clk,
   output logic rst_n
);

   initial begin
      sys_clk = 1'b0;
      forever #(PERIOD / 2) sys_clk = ~sys_clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge sys_clk);
      rst_n <= 1'b1; // released on the third rising edge
   end

endmodule

// ==== design/vdp_top.sv ====
`timescale 1ns/1ps

module vdp_top
   import vdp_pkg::*;
#(
   parameter  int COLS    = 8,
   parameter  int VRAM_AW = 12,
   parameter  int CREDITS = 2,
   localparam int XW      = $clog2(COLS * 8)
) (
   input  logic          sys_clk,
   input  logic          rst_n,
   input  logic [15:0]   cpu_addr,
   input  byte_t         cpu_wr_data,
   input  logic          cpu_wr_en,
   input  logic          frame_start,
   input  logic          line_start,
   output byte_t         cpu_rd_data,
   output logic          pix_valid,
   output logic [XW-1:0] pix_x,
   output color_t        pix_color
);

   // register window
   logic [VRAM_AW-1:0] dl_addr;
   byte_t              charset_base;
   logic               wr_en;
   logic [VRAM_AW-1:0] wr_addr;
   logic [1:0]         wr_be;
   word_t              wr_data;

   // shared vram read port
   logic               dl_rd_en;
   logic [VRAM_AW-1:0] dl_rd_addr;
   logic               tf_rd_en;
   logic [VRAM_AW-1:0] tf_rd_addr;
   word_t              rd_data;

   // per-scanline render request
   logic               line_go;
   logic [VRAM_AW:0]   text_addr;
   logic [VRAM_AW:0]   attr_addr;
   logic [2:0]         row_line;

   // pixel groups under credits
   logic               grp_valid;
   byte_t              grp_bits;
   byte_t              grp_attr;
   logic [XW-1:0]      grp_x;
   logic               credit_ret;

   vdp_regs #(
      .VRAM_AW(VRAM_AW)
   ) u_regs (
      .*
   );

   vram #(
      .VRAM_AW(VRAM_AW)
   ) u_vram (
      .*
   );

   dl_decoder #(
      .COLS   (COLS),
      .VRAM_AW(VRAM_AW)
   ) u_dl_decoder (
      .*
   );

   text_fetch #(
      .COLS   (COLS),
      .VRAM_AW(VRAM_AW),
      .CREDITS(CREDITS)
   ) u_text_fetch (
      .*
   );

   line_writer #(
      .COLS   (COLS),
      .CREDITS(CREDITS)
   ) u_line_writer (
      .*
   );

endmodule

// ==== design/line_writer.sv ====
`timescale 1ns/1ps

module line_writer
   import vdp_pkg::*;
#(
   parameter  int COLS    = 8,
   parameter  int CREDITS = 2,
   localparam int XW      = $clog2(COLS * 8)
) (
   input  logic          sys_clk,
   input  logic          rst_n,
   input  logic          grp_valid,
   input  byte_t         grp_bits,
   input  byte_t         grp_attr,
   input  logic [XW-1:0] grp_x,
   output logic          credit_ret,
   output logic          pix_valid,
   output logic [XW-1:0] pix_x,
   output color_t        pix_color
);

   localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
   localparam int CW = $clog2(CREDITS + 1);

   byte_t         q_bits [CREDITS];
   byte_t         q_attr [CREDITS];
   logic [XW-1:0] q_x    [CREDITS];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] q_cnt;
   logic          busy;
   logic [2:0]    bit_cnt;
   byte_t         sh_bits;
   byte_t         sh_attr;
   logic [XW-1:0] sh_x;
   logic          load;

   // next group goes in behind the eighth pixel without a gap
   assign load       = q_cnt != 0 && (!busy || bit_cnt == 3'd7);
   assign pix_valid  = busy;
   assign pix_x      = sh_x + XW'(bit_cnt);
   assign pix_color  = sh_bits[7] ? sh_attr[3:0] : sh_attr[7:4]; // fg low nibble
   assign credit_ret = busy && bit_cnt == 3'd7;

   always_ff @(posedge sys_clk) begin
      if (grp_valid) begin
         q_bits[wr_ptr] <= grp_bits;
         q_attr[wr_ptr] <= grp_attr;
         q_x[wr_ptr]    <= grp_x;
      end
      if (load) begin
         sh_bits <= q_bits[rd_ptr];
         sh_attr <= q_attr[rd_ptr];
         sh_x    <= q_x[rd_ptr];
      end else if (busy) begin
         sh_bits <= sh_bits << 1; // msb first
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         q_cnt   <= '0;
         busy    <= 1'b0;
         bit_cnt <= '0;
      end else begin
         if (grp_valid)
            wr_ptr <= (wr_ptr == PW'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
         if (load)
            rd_ptr <= (rd_ptr == PW'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
         q_cnt <= q_cnt + CW'(grp_valid) - CW'(load);
         if (load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
         end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
               busy <= 1'b0;
         end
      end
   end

endmodule

// ==== design/text_fetch.sv ====
`timescale 1ns/1ps

module text_fetch
   import vdp_pkg::*;
#(
   parameter  int COLS    = 8,
   parameter  int VRAM_AW = 12,
   parameter  int CREDITS = 2,
   localparam int XW      = $clog2(COLS * 8)
) (
   input  logic               sys_clk,
   input  logic               rst_n,
   input  logic               frame_start,
   input  logic               line_go,
   input  logic [VRAM_AW:0]   text_addr,
   input  logic [VRAM_AW:0]   attr_addr,
   input  logic [2:0]         row_line,
   input  byte_t              charset_base,
   input  word_t              rd_data,
   input  logic               credit_ret,
   output logic               tf_rd_en,
   output logic [VRAM_AW-1:0] tf_rd_addr,
   output logic               grp_valid,
   output byte_t              grp_bits,
   output byte_t              grp_attr,
   output logic [XW-1:0]      grp_x
);

   localparam int CIW = XW - 3;              // column index
   localparam int RIW = $clog2(2 * COLS + 1);
   localparam int CRW = $clog2(CREDITS + 1);

   typedef enum logic [2:0] {
      T_IDLE,
      T_ROW,
      T_FONT_RD,
      T_FONT_WAIT,
      T_SEND
   } state_t;

   state_t           state;
   byte_t            chars [COLS];
   byte_t            attrs [COLS];
   logic [RIW-1:0]   ri;         // next char/attr request with chars first
   logic [RIW-1:0]   rsp_idx;
   logic             rsp_valid;
   logic             rsp_sel;    // high byte of the returned word
   logic [CIW-1:0]   col;
   logic [CRW-1:0]   credits;
   logic [VRAM_AW:0] row_addr;
   logic [17:0]      font_full;
   logic [VRAM_AW:0] rd_byte_addr;
   byte_t            rd_byte;
   logic             send;

   always_comb begin
      if (ri < RIW'(COLS))
         row_addr = text_addr + (VRAM_AW + 1)'(ri);
      else
         row_addr = attr_addr + (VRAM_AW + 1)'(ri - RIW'(COLS));
   end

   // charset_base*1024 + code*8 + line before the cut to the vram byte width
   assign font_full    = {charset_base, 10'b0} + {7'b0, chars[col], 3'b0} + 18'(row_line);
   assign rd_byte_addr = (state == T_ROW) ? row_addr : font_full[VRAM_AW:0];
   assign tf_rd_en     = (state == T_ROW && ri < RIW'(2 * COLS)) || state == T_FONT_RD;
   assign tf_rd_addr   = rd_byte_addr[VRAM_AW:1];
   assign rd_byte      = rsp_sel ? rd_data[15:8] : rd_data[7:0];
   assign send         = state == T_SEND && credits != 0 && !frame_start;

   always_ff @(posedge sys_clk) begin
      grp_valid <= 1'b0;
      if (!rst_n || frame_start) begin
         state     <= T_IDLE;
         rsp_valid <= 1'b0;
         ri        <= '0;
         col       <= '0;
      end else begin
         if (tf_rd_en)
            rsp_sel <= rd_byte_addr[0];
         rsp_valid <= tf_rd_en && state == T_ROW;
         rsp_idx   <= ri;
         if (rsp_valid) begin
            if (rsp_idx < RIW'(COLS))
               chars[CIW'(rsp_idx)] <= rd_byte;
            else
               attrs[CIW'(rsp_idx - RIW'(COLS))] <= rd_byte;
         end
         case (state)
            T_IDLE:
               if (line_go) begin
                  ri    <= '0;
                  state <= T_ROW;
               end
            T_ROW: begin
               if (ri < RIW'(2 * COLS))
                  ri <= ri + 1'b1;
               if (rsp_valid && rsp_idx == RIW'(2 * COLS - 1)) begin // last attr back
                  col   <= '0;
                  state <= T_FONT_RD;
               end
            end
            T_FONT_RD: state <= T_FONT_WAIT;
            T_FONT_WAIT: begin
               grp_bits <= rd_byte;
               grp_attr <= attrs[col];
               grp_x    <= {col, 3'b000};
               state    <= T_SEND;
            end
            T_SEND:
               if (send) begin
                  grp_valid <= 1'b1;
                  if (col == CIW'(COLS - 1)) begin
                     state <= T_IDLE;
                  end else begin
                     col   <= col + 1'b1;
                     state <= T_FONT_RD;
                  end
               end
            default: state <= T_IDLE;
         endcase
      end
   end

   // free slots in the line writer
   always_ff @(posedge sys_clk) begin
      if (!rst_n)
         credits <= CRW'(CREDITS);
      else
         credits <= credits + CRW'(credit_ret) - CRW'(send);
   end

endmodule

// ==== design/dl_decoder.sv ====
`timescale 1ns/1ps

module dl_decoder
   import vdp_pkg::*;
#(
   parameter int COLS    = 8,
   parameter int VRAM_AW = 12
) (
   input  logic               sys_clk,
   input  logic               rst_n,
   input  logic               frame_start,
   input  logic               line_start,
   input  logic [VRAM_AW-1:0] dl_addr,
   input  word_t              rd_data,
   output logic               dl_rd_en,
   output logic [VRAM_AW-1:0] dl_rd_addr,
   output logic               line_go,
   output logic [VRAM_AW:0]   text_addr,
   output logic [VRAM_AW:0]   attr_addr,
   output logic [2:0]         row_line
);

   typedef enum logic [3:0] {
      S_IDLE,
      S_RD_ENTRY,
      S_GET_ENTRY,
      S_RD_TEXT,
      S_GET_TEXT,
      S_RD_ATTR,
      S_GET_ATTR,
      S_GO,
      S_END
   } state_t;

   state_t             state;
   dl_mode_t           mode;
   logic [VRAM_AW-1:0] ptr;
   logic [7:0]         lines_left;
   logic [2:0]         row;        // font line of the next scanline
   logic [VRAM_AW:0]   text_base;
   logic [VRAM_AW:0]   attr_base;

   assign dl_rd_en   = state == S_RD_ENTRY || state == S_RD_TEXT || state == S_RD_ATTR;
   assign dl_rd_addr = ptr;

   always_ff @(posedge sys_clk) begin
      line_go <= 1'b0;
      if (!rst_n || frame_start) begin
         state      <= S_IDLE;
         mode       <= DL_BLANK;
         ptr        <= dl_addr;
         lines_left <= '0;
         row        <= '0;
      end else begin
         if (dl_rd_en)
            ptr <= ptr + 1'b1;
         case (state)
            S_IDLE:
               if (line_start) begin
                  if (lines_left == 0) begin
                     state <= S_RD_ENTRY;
                  end else begin
                     lines_left <= lines_left - 1'b1;
                     if (mode == DL_TEXT)
                        state <= S_GO;
                  end
               end
            S_RD_ENTRY: state <= S_GET_ENTRY;
            S_GET_ENTRY: begin
               lines_left <= rd_data[7:0] - 1'b1; // this scanline is the first
               case (rd_data[11:8])
                  DL_TEXT: begin
                     mode  <= DL_TEXT;
                     state <= S_RD_TEXT;
                  end
                  DL_END: begin
                     mode  <= DL_END;
                     state <= S_END;
                  end
                  default: begin
                     mode  <= DL_BLANK;
                     state <= S_IDLE;
                  end
               endcase
            end
            S_RD_TEXT: state <= S_GET_TEXT;
            S_GET_TEXT: begin
               text_base <= rd_data[VRAM_AW:0];
               state     <= S_RD_ATTR;
            end
            S_RD_ATTR: state <= S_GET_ATTR;
            S_GET_ATTR: begin
               attr_base <= rd_data[VRAM_AW:0];
               row       <= '0;
               state     <= S_GO;
            end
            S_GO: begin
               line_go   <= 1'b1;
               text_addr <= text_base;
               attr_addr <= attr_base;
               row_line  <= row;
               row       <= row + 1'b1;
               if (row == 3'(ROW_LINES - 1)) begin
                  // next character row
                  text_base <= text_base + (VRAM_AW + 1)'(COLS);
                  attr_base <= attr_base + (VRAM_AW + 1)'(COLS);
               end
               state <= S_IDLE;
            end
            S_END: ; // parked until frame_start
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// ==== design/vram.sv ====
`timescale 1ns/1ps

module vram
   import vdp_pkg::*;
#(
   parameter int VRAM_AW = 12
) (
   input  logic               sys_clk,
   input  logic               wr_en,
   input  logic [VRAM_AW-1:0] wr_addr,
   input  logic [1:0]         wr_be,
   input  word_t              wr_data,
   input  logic               dl_rd_en,
   input  logic [VRAM_AW-1:0] dl_rd_addr,
   input  logic               tf_rd_en,
   input  logic [VRAM_AW-1:0] tf_rd_addr,
   output word_t              rd_data
);

   word_t              mem [2**VRAM_AW];
   logic [VRAM_AW-1:0] rd_addr;

   assign rd_addr = dl_rd_en ? dl_rd_addr : tf_rd_addr; // display list wins

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         if (wr_be[0])
            mem[wr_addr][7:0] <= wr_data[7:0];
         if (wr_be[1])
            mem[wr_addr][15:8] <= wr_data[15:8];
      end
   end

   always_ff @(posedge sys_clk) begin
      if (dl_rd_en || tf_rd_en)
         rd_data <= mem[rd_addr];
   end

endmodule

// ==== design/vdp_regs.sv ====
`timescale 1ns/1ps

module vdp_regs
   import vdp_pkg::*;
#(
   parameter int VRAM_AW = 12
) (
   input  logic               sys_clk,
   input  logic               rst_n,
   input  logic [15:0]        cpu_addr,
   input  byte_t              cpu_wr_data,
   input  logic               cpu_wr_en,
   output byte_t              cpu_rd_data,
   output logic [VRAM_AW-1:0] dl_addr,
   output byte_t              charset_base,
   output logic               wr_en,
   output logic [VRAM_AW-1:0] wr_addr,
   output logic [1:0]         wr_be,
   output word_t              wr_data
);

   logic [15:0] dl_reg;
   logic [15:0] vaddr;   // vram byte address
   logic        cpu_wr_en_d;
   logic        reg_cs;
   logic        wr_rise;
   logic        vdata_wr;

   assign reg_cs   = cpu_addr[15:7] == REG_BASE;
   assign wr_rise  = cpu_wr_en && !cpu_wr_en_d;
   assign vdata_wr = reg_cs && wr_rise && cpu_addr[6:0] == REG_VDATA;
   assign dl_addr  = dl_reg[VRAM_AW-1:0];

   always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
         cpu_wr_en_d  <= 1'b0;
         wr_en        <= 1'b0;
         dl_reg       <= '0;
         charset_base <= '0;
         vaddr        <= '0;
      end else begin
         cpu_wr_en_d <= cpu_wr_en;
         wr_en       <= vdata_wr;
         if (reg_cs && wr_rise) begin
            case (cpu_addr[6:0])
               REG_DL_LO:    dl_reg[7:0]  <= cpu_wr_data;
               REG_DL_HI:    dl_reg[15:8] <= cpu_wr_data;
               REG_CHARSET:  charset_base <= cpu_wr_data;
               REG_VADDR_LO: vaddr[7:0]   <= cpu_wr_data;
               REG_VADDR_HI: vaddr[15:8]  <= cpu_wr_data;
               REG_VDATA:    vaddr        <= vaddr + 1'b1;
               default: ;
            endcase
         end
      end
   end

   // data port write, same byte on both halves and the lsb picks the lane
   always_ff @(posedge sys_clk) begin
      if (vdata_wr) begin
         wr_addr <= vaddr[VRAM_AW:1];
         wr_data <= {cpu_wr_data, cpu_wr_data};
         wr_be   <= vaddr[0] ? 2'b10 : 2'b01;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reg_cs) begin
         cpu_rd_data <= '0;
      end else begin
         case (cpu_addr[6:0])
            REG_DL_LO:    cpu_rd_data <= dl_reg[7:0];
            REG_DL_HI:    cpu_rd_data <= dl_reg[15:8];
            REG_CHARSET:  cpu_rd_data <= charset_base;
            REG_VADDR_LO: cpu_rd_data <= vaddr[7:0];
            REG_VADDR_HI: cpu_rd_data <= vaddr[15:8];
            default:      cpu_rd_data <= '0;
         endcase
      end
   end

endmodule

// ==== design/vdp_pkg.sv ====
package vdp_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] word_t;
   typedef logic [3:0]  color_t;

   // display-list entry mode, bits 11..8 of the entry word
   typedef enum logic [3:0] {
      DL_BLANK = 4'h0,
      DL_TEXT  = 4'h1,
      DL_END   = 4'hf
   } dl_mode_t;

   // cpu_addr[15:7] of the register window
   localparam logic [8:0] REG_BASE = 9'h120;

   localparam logic [6:0] REG_DL_LO    = 7'h00;
   localparam logic [6:0] REG_DL_HI    = 7'h01;
   localparam logic [6:0] REG_CHARSET  = 7'h02;
   localparam logic [6:0] REG_VADDR_LO = 7'h06;
   localparam logic [6:0] REG_VADDR_HI = 7'h07;
   localparam logic [6:0] REG_VDATA    = 7'h09;

   localparam int ROW_LINES = 8; // scanlines per character row

endpackage
